/* source/ip_rx_pkg.sv */
// shared widths, beat and header structs, the control enum and keep helpers for the IPv4 receiver
package ip_rx_pkg;

    localparam int DATA_BYTES   = 8;
    localparam int IP_HDR_BYTES = 20;
    localparam int IP_VERSION   = 4;
    localparam int IP_IHL       = 5;

    typedef logic [DATA_BYTES*8-1:0] word_t;
    typedef logic [DATA_BYTES-1:0]   keep_t;
    typedef logic [15:0]             length_t;
    typedef logic [31:0]             ipv4_addr_t;

    typedef struct packed {
        word_t data;
        keep_t keep;
        logic  last;
    } axis_beat_t;

    // fields in network order, version at the top
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        length_t     total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        ipv4_addr_t  source_addr;
        ipv4_addr_t  dest_addr;
    } ip_hdr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_HOLD_LAST,
        ST_DROP
    } rx_state_t;

    // keep is contiguous from bit 0, so the count is the number of ones
    function automatic logic [3:0] keep_to_count(keep_t keep);
        return 4'($countones(keep));
    endfunction

    function automatic keep_t count_to_keep(logic [3:0] count);
        return keep_t'((9'd1 << count) - 9'd1);
    endfunction

endpackage

/* source/ip_hdr_capture.sv */
// collects the IPv4 header fields from the first three words and checks version and IHL
`timescale 1ns/1ps

module ip_hdr_capture (
    input  logic               clk,
    input  logic               rst,
    input  logic               store_word,
    input  logic [1:0]         word_index,
    input  ip_rx_pkg::word_t   data,
    output ip_rx_pkg::ip_hdr_t hdr,
    output logic               header_ok
);

    // version sits in word 0, so the verdict is ready when word 2 arrives
    assign header_ok = (hdr.version == 4'(ip_rx_pkg::IP_VERSION)) &&
                       (hdr.ihl == 4'(ip_rx_pkg::IP_IHL));

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr <= '0;
        end else if (store_word) begin
            case (word_index)
                2'd0: begin
                    {hdr.version, hdr.ihl} <= data[7:0];
                    {hdr.dscp, hdr.ecn} <= data[15:8];
                    hdr.total_length <= {data[23:16], data[31:24]};
                    hdr.identification <= {data[39:32], data[47:40]};
                    {hdr.flags, hdr.fragment_offset} <= {data[55:48], data[63:56]};
                end
                2'd1: begin
                    hdr.ttl <= data[7:0];
                    hdr.protocol <= data[15:8];
                    hdr.header_checksum <= {data[23:16], data[31:24]};
                    hdr.source_addr <= {data[39:32], data[47:40], data[55:48], data[63:56]};
                end
                2'd2: begin
                    // upper half is payload
                    hdr.dest_addr <= {data[7:0], data[15:8], data[23:16], data[31:24]};
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* source/ip_hdr_checksum.sv */
// one's-complement sum over the ten header halfwords, checked the cycle after word 2
`timescale 1ns/1ps

module ip_hdr_checksum (
    input  logic             clk,
    input  logic             rst,
    input  logic             store_word,
    input  logic [1:0]       word_index,
    input  ip_rx_pkg::word_t data,
    output logic             checksum_ok
);

    logic [31:0] acc;
    logic [31:0] lanes;
    logic [16:0] fold1;
    logic [16:0] fold2;

    // lane byte order does not matter for an end-around carry sum
    always_comb begin
        lanes = 32'(data[15:0]) + 32'(data[31:16]);
        if (word_index != 2'd2) begin
            lanes = lanes + 32'(data[47:32]) + 32'(data[63:48]);
        end
        fold1 = 17'(acc[15:0]) + 17'(acc[31:16]);
        fold2 = 17'(fold1[15:0]) + 17'(fold1[16]);
    end

    assign checksum_ok = (fold2[15:0] == 16'hffff);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (store_word) begin
            acc <= (word_index == 2'd0) ? lanes : acc + lanes;
        end
    end

endmodule

/* source/payload_realign.sv */
// shifts the payload down four byte lanes, adding a closing beat when the tail spills over
`timescale 1ns/1ps

module payload_realign (
    input  logic                  clk,
    input  logic                  rst,
    input  ip_rx_pkg::axis_beat_t in_beat,
    input  logic                  in_valid,
    input  logic                  take,
    input  logic                  flush,
    output ip_rx_pkg::axis_beat_t realigned,
    output logic                  realigned_valid
);

    ip_rx_pkg::axis_beat_t saved;
    logic extra;

    // saved beat ended the frame but still holds bytes in its upper half
    assign extra = saved.last & (saved.keep[7:4] != 4'd0);

    always_comb begin
        realigned.data[31:0] = saved.data[63:32];
        realigned.keep[3:0] = saved.keep[7:4];
        if (extra) begin
            realigned.data[63:32] = '0;
            realigned.keep[7:4] = '0;
            realigned.last = 1'b1;
            realigned_valid = 1'b1;
        end else begin
            realigned.data[63:32] = in_beat.data[31:0];
            realigned.keep[7:4] = in_beat.keep[3:0];
            realigned.last = in_beat.last & (in_beat.keep[7:4] == 4'd0);
            realigned_valid = in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            saved <= '0;
        end else if (take) begin
            if (extra) begin
                // closing beat consumed, nothing left
                saved <= '0;
            end else begin
                saved <= in_beat;
            end
        end
    end

endmodule

/* source/payload_skid_buffer.sv */
// two-entry output register pair with an early ready for the registered upstream ready
`timescale 1ns/1ps

module payload_skid_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  ip_rx_pkg::axis_beat_t push_beat,
    input  logic                  push_valid,
    output logic                  early_ready,
    output ip_rx_pkg::axis_beat_t out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    ip_rx_pkg::axis_beat_t temp_beat;
    logic temp_valid;

    // ready next cycle if the output drains, or a slot stays free after this push
    assign early_ready = out_ready |
                         (~temp_valid & ~out_valid) |
                         (~temp_valid & ~push_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
        end else if (push_valid) begin
            if (out_ready | ~out_valid) begin
                out_valid <= 1'b1;
            end else begin
                temp_valid <= 1'b1;
            end
        end else if (out_ready) begin
            out_valid <= temp_valid;
            temp_valid <= 1'b0;
        end
    end

    // payload registers follow the same steering as the valids
    always_ff @(posedge clk) begin
        if (push_valid) begin
            if (out_ready | ~out_valid) begin
                out_beat <= push_beat;
            end else begin
                temp_beat <= push_beat;
            end
        end else if (out_ready) begin
            out_beat <= temp_beat;
        end
    end

endmodule

/* source/ip_rx_ctrl.sv */
// frame FSM, steps through header words, forwards and trims payload, drops bad frames
`timescale 1ns/1ps

module ip_rx_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic                  in_last,
    output logic                  in_ready,
    output logic                  store_word,
    output logic [1:0]            word_index,
    input  logic                  header_ok,
    input  logic                  checksum_ok,
    input  ip_rx_pkg::length_t    total_length,
    input  ip_rx_pkg::axis_beat_t realigned,
    input  logic                  realigned_valid,
    output logic                  take,
    output logic                  flush,
    output ip_rx_pkg::axis_beat_t push_beat,
    output logic                  push_valid,
    input  logic                  early_ready,
    output logic                  hdr_valid,
    input  logic                  hdr_ready,
    output logic                  error_invalid_header,
    output logic                  error_invalid_checksum
);

    ip_rx_pkg::rx_state_t  state, state_next;
    ip_rx_pkg::length_t    ptr, ptr_next, plen;
    ip_rx_pkg::axis_beat_t hold_beat;
    logic [1:0] word_next;
    logic in_ready_next, space, extra, extra_next, check, check_next;
    logic hdr_valid_next, accept, avail, store_hold;
    logic bad_hdr_next, bad_sum_next;
    ip_rx_pkg::keep_t trim_keep;

    assign plen = total_length - ip_rx_pkg::length_t'(ip_rx_pkg::IP_HDR_BYTES);
    assign accept = in_valid & in_ready;
    assign store_word = accept &
                        (state == ip_rx_pkg::ST_IDLE || state == ip_rx_pkg::ST_HEADER);
    assign flush = (state == ip_rx_pkg::ST_IDLE);
    // output space known one cycle ahead, extra closing beat needs no input
    assign avail = realigned_valid & space & (extra | in_ready);

    always_comb begin
        state_next = state;
        ptr_next = ptr;
        word_next = word_index;
        extra_next = extra;
        take = 1'b0;
        push_valid = 1'b0;
        push_beat = realigned;
        store_hold = 1'b0;
        trim_keep = realigned.keep & ip_rx_pkg::count_to_keep(4'(plen - ptr));
        check_next = 1'b0;
        bad_hdr_next = 1'b0;
        bad_sum_next = check & ~checksum_ok;
        hdr_valid_next = (hdr_valid & ~hdr_ready) | (check & checksum_ok);
        if (accept & in_last & ~realigned.last) begin
            extra_next = 1'b1;
        end

        case (state)
            ip_rx_pkg::ST_IDLE: begin
                ptr_next = '0;
                if (accept) begin
                    take = 1'b1;
                    word_next = 2'd1;
                    state_next = in_last ? ip_rx_pkg::ST_IDLE : ip_rx_pkg::ST_HEADER;
                end
            end
            ip_rx_pkg::ST_HEADER: begin
                if (accept) begin
                    take = 1'b1;
                    word_next = word_index + 2'd1;
                    if (word_index == 2'd2) begin
                        check_next = header_ok;
                        bad_hdr_next = ~header_ok;
                        if (realigned.last) begin
                            state_next = ip_rx_pkg::ST_IDLE;
                        end else if (!header_ok || plen == '0) begin
                            state_next = ip_rx_pkg::ST_DROP;
                        end else begin
                            state_next = ip_rx_pkg::ST_PAYLOAD;
                        end
                    end else if (in_last) begin
                        state_next = ip_rx_pkg::ST_IDLE;
                    end
                end
            end
            ip_rx_pkg::ST_PAYLOAD: begin
                if (avail) begin
                    take = 1'b1;
                    ptr_next = ptr + 16'(ip_rx_pkg::keep_to_count(realigned.keep));
                    if (ptr_next >= plen) begin
                        ptr_next = plen;
                        push_beat.keep = trim_keep;
                        if (realigned.last) begin
                            push_valid = 1'b1;
                            state_next = ip_rx_pkg::ST_IDLE;
                        end else begin
                            // wait for the frame end before issuing last
                            store_hold = 1'b1;
                            state_next = ip_rx_pkg::ST_HOLD_LAST;
                        end
                    end else begin
                        push_valid = 1'b1;
                        if (realigned.last) begin
                            state_next = ip_rx_pkg::ST_IDLE;
                        end
                    end
                end
                if (bad_sum_next) begin
                    push_valid = 1'b0;
                    state_next = (take & realigned.last) ? ip_rx_pkg::ST_IDLE
                                                         : ip_rx_pkg::ST_DROP;
                end
            end
            ip_rx_pkg::ST_HOLD_LAST: begin
                push_beat = hold_beat;
                if (avail) begin
                    take = 1'b1;
                    if (realigned.last) begin
                        push_valid = 1'b1;
                        state_next = ip_rx_pkg::ST_IDLE;
                    end
                end
            end
            default: begin
                // drop, consume until the frame ends
                if (realigned_valid & (extra | in_ready)) begin
                    take = 1'b1;
                    if (realigned.last) begin
                        state_next = ip_rx_pkg::ST_IDLE;
                    end
                end
            end
        endcase

        // the first beat seen in idle is always header word 0
        if (state_next == ip_rx_pkg::ST_IDLE) begin
            word_next = 2'd0;
        end

        if (take & extra) begin
            extra_next = 1'b0;
        end

        case (state_next)
            ip_rx_pkg::ST_IDLE:   in_ready_next = ~hdr_valid_next & ~check_next;
            ip_rx_pkg::ST_HEADER: in_ready_next = 1'b1;
            ip_rx_pkg::ST_DROP:   in_ready_next = ~extra_next;
            default:              in_ready_next = early_ready & ~extra_next;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ip_rx_pkg::ST_IDLE;
            ptr <= '0;
            word_index <= 2'd0;
            extra <= 1'b0;
            check <= 1'b0;
            space <= 1'b0;
            in_ready <= 1'b0;
            hdr_valid <= 1'b0;
            error_invalid_header <= 1'b0;
            error_invalid_checksum <= 1'b0;
        end else begin
            state <= state_next;
            ptr <= ptr_next;
            word_index <= word_next;
            extra <= extra_next;
            check <= check_next;
            space <= early_ready;
            in_ready <= in_ready_next;
            hdr_valid <= hdr_valid_next;
            error_invalid_header <= bad_hdr_next;
            error_invalid_checksum <= bad_sum_next;
        end
    end

    // trimmed final word, released with last at the frame end
    always_ff @(posedge clk) begin
        if (store_hold) begin
            hold_beat.data <= realigned.data;
            hold_beat.keep <= trim_keep;
            hold_beat.last <= 1'b1;
        end
    end

endmodule

/* source/ip_rx_top.sv */
// IPv4 receiver top, strips the 20-byte header from a 64-bit stream and emits header and payload
`timescale 1ns/1ps

module ip_rx_top (
    input  logic                 clk,
    input  logic                 rst,
    input  ip_rx_pkg::axis_beat_t in_beat,
    input  logic                 in_valid,
    output logic                 in_ready,
    output ip_rx_pkg::ip_hdr_t   hdr,
    output logic                 hdr_valid,
    input  logic                 hdr_ready,
    output ip_rx_pkg::axis_beat_t out_beat,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 error_invalid_header,
    output logic                 error_invalid_checksum
);

    logic                  store_word;
    logic [1:0]            word_index;
    logic                  header_ok;
    logic                  checksum_ok;
    ip_rx_pkg::axis_beat_t realigned;
    logic                  realigned_valid;
    logic                  take;
    logic                  flush;
    ip_rx_pkg::axis_beat_t push_beat;
    logic                  push_valid;
    logic                  early_ready;

    ip_rx_ctrl ctrl_i (
        .clk                   (clk),
        .rst                   (rst),
        .in_valid              (in_valid),
        .in_last               (in_beat.last),
        .in_ready              (in_ready),
        .store_word            (store_word),
        .word_index            (word_index),
        .header_ok             (header_ok),
        .checksum_ok           (checksum_ok),
        .total_length          (hdr.total_length),
        .realigned             (realigned),
        .realigned_valid       (realigned_valid),
        .take                  (take),
        .flush                 (flush),
        .push_beat             (push_beat),
        .push_valid            (push_valid),
        .early_ready           (early_ready),
        .hdr_valid             (hdr_valid),
        .hdr_ready             (hdr_ready),
        .error_invalid_header  (error_invalid_header),
        .error_invalid_checksum(error_invalid_checksum)
    );

    ip_hdr_capture capture_i (
        .clk       (clk),
        .rst       (rst),
        .store_word(store_word),
        .word_index(word_index),
        .data      (in_beat.data),
        .hdr       (hdr),
        .header_ok (header_ok)
    );

    ip_hdr_checksum checksum_i (
        .clk        (clk),
        .rst        (rst),
        .store_word (store_word),
        .word_index (word_index),
        .data       (in_beat.data),
        .checksum_ok(checksum_ok)
    );

    payload_realign realign_i (
        .clk            (clk),
        .rst            (rst),
        .in_beat        (in_beat),
        .in_valid       (in_valid),
        .take           (take),
        .flush          (flush),
        .realigned      (realigned),
        .realigned_valid(realigned_valid)
    );

    payload_skid_buffer skid_i (
        .clk        (clk),
        .rst        (rst),
        .push_beat  (push_beat),
        .push_valid (push_valid),
        .early_ready(early_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

/* verification/ip_rx_checker.sv */
// scoreboard for the IPv4 receiver, models each frame and checks headers, payload and error pulses
`timescale 1ns/1ps

module ip_rx_checker (
    input logic                  clk,
    input logic                  rst,
    input ip_rx_pkg::ip_hdr_t    hdr,
    input logic                  hdr_valid,
    input logic                  hdr_ready,
    input ip_rx_pkg::axis_beat_t out_beat,
    input logic                  out_valid,
    input logic                  out_ready,
    input logic                  error_invalid_header,
    input logic                  error_invalid_checksum
);

    typedef enum int {
        FRAME_GOOD,
        FRAME_BAD_HEADER,
        FRAME_BAD_CHECKSUM
    } frame_kind_t;

    ip_rx_pkg::ip_hdr_t exp_hdrs[$];
    logic [7:0]         exp_bytes[$];
    int                 exp_lens[$];
    int remaining = 0;
    int exp_bad_header = 0;
    int exp_bad_checksum = 0;
    int seen_bad_header = 0;
    int seen_bad_checksum = 0;
    int checks = 0;
    int errors = 0;

    // expected header and payload of one frame, straight from its bytes
    function automatic frame_kind_t ip_rx_model(input logic [7:0] frame[$],
                                                output ip_rx_pkg::ip_hdr_t h,
                                                output logic [7:0] payload[$]);
        logic [31:0] sum;
        int stop;
        h = '0;
        payload = {};
        h.version = frame[0][7:4];
        h.ihl = frame[0][3:0];
        h.dscp = frame[1][7:2];
        h.ecn = frame[1][1:0];
        h.total_length = {frame[2], frame[3]};
        h.identification = {frame[4], frame[5]};
        h.flags = frame[6][7:5];
        h.fragment_offset = {frame[6][4:0], frame[7]};
        h.ttl = frame[8];
        h.protocol = frame[9];
        h.header_checksum = {frame[10], frame[11]};
        h.source_addr = {frame[12], frame[13], frame[14], frame[15]};
        h.dest_addr = {frame[16], frame[17], frame[18], frame[19]};
        if (h.version != 4'd4 || h.ihl != 4'd5) begin
            return FRAME_BAD_HEADER;
        end
        sum = '0;
        for (int i = 0; i < 20; i += 2) begin
            sum = sum + 32'({frame[i], frame[i + 1]});
        end
        while (sum[31:16] != 16'd0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        end
        if (sum[15:0] != 16'hffff) begin
            return FRAME_BAD_CHECKSUM;
        end
        // payload stops at total length or at the frame end
        stop = (int'(h.total_length) < frame.size()) ? int'(h.total_length) : frame.size();
        for (int i = 20; i < stop; i++) begin
            payload.push_back(frame[i]);
        end
        return FRAME_GOOD;
    endfunction

    task automatic expect_frame(input logic [7:0] frame[$]);
        ip_rx_pkg::ip_hdr_t h;
        logic [7:0] payload[$];
        frame_kind_t kind;
        kind = ip_rx_model(frame, h, payload);
        if (kind == FRAME_BAD_HEADER) begin
            exp_bad_header++;
        end else if (kind == FRAME_BAD_CHECKSUM) begin
            exp_bad_checksum++;
        end else begin
            exp_hdrs.push_back(h);
            if (payload.size() > 0) begin
                exp_lens.push_back(payload.size());
                foreach (payload[i]) begin
                    exp_bytes.push_back(payload[i]);
                end
            end
        end
    endtask

    task automatic compare_header();
        ip_rx_pkg::ip_hdr_t e;
        checks++;
        if (exp_hdrs.size() == 0) begin
            errors++;
            $display("header accepted from the DUT while no good frame was pending");
            return;
        end
        e = exp_hdrs.pop_front();
        if (hdr !== e) begin
            errors++;
            $display("[FAIL] hdr expected %h got %h", e, hdr);
        end
    endtask

    task automatic compare_beat();
        ip_rx_pkg::word_t exp_data;
        ip_rx_pkg::word_t mask;
        ip_rx_pkg::keep_t exp_keep;
        logic exp_last;
        int n;
        checks++;
        if (remaining == 0) begin
            if (exp_lens.size() == 0) begin
                errors++;
                $display("payload beat accepted from the DUT while no payload was pending");
                return;
            end
            remaining = exp_lens.pop_front();
        end
        n = (remaining < 8) ? remaining : 8;
        exp_keep = ip_rx_pkg::count_to_keep(4'(n));
        exp_last = (remaining == n);
        exp_data = '0;
        mask = '0;
        for (int i = 0; i < n; i++) begin
            exp_data[i*8 +: 8] = exp_bytes.pop_front();
            mask[i*8 +: 8] = 8'hff;
        end
        remaining = remaining - n;
        if (out_beat.keep !== exp_keep) begin
            errors++;
            $display("[FAIL] out_beat.keep expected %h got %h", exp_keep, out_beat.keep);
        end
        if (out_beat.last !== exp_last) begin
            errors++;
            $display("[FAIL] out_beat.last expected %h got %h", exp_last, out_beat.last);
        end
        if ((out_beat.data & mask) !== exp_data) begin
            errors++;
            $display("[FAIL] out_beat.data expected %h got %h", exp_data, out_beat.data & mask);
        end
    endtask

    // all outputs delivered and every expected pulse seen
    function automatic logic drained();
        return exp_hdrs.size() == 0 && exp_lens.size() == 0 && remaining == 0 &&
               seen_bad_header >= exp_bad_header && seen_bad_checksum >= exp_bad_checksum;
    endfunction

    task automatic check_pulse_counts();
        checks += 2;
        if (seen_bad_header != exp_bad_header) begin
            errors++;
            $display("[FAIL] error_invalid_header pulses expected %h got %h",
                     exp_bad_header, seen_bad_header);
        end
        if (seen_bad_checksum != exp_bad_checksum) begin
            errors++;
            $display("[FAIL] error_invalid_checksum pulses expected %h got %h",
                     exp_bad_checksum, seen_bad_checksum);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (hdr_valid && hdr_ready) begin
                compare_header();
            end
            if (out_valid && out_ready) begin
                compare_beat();
            end
            if (error_invalid_header) begin
                seen_bad_header++;
            end
            if (error_invalid_checksum) begin
                seen_bad_checksum++;
            end
        end
    end

endmodule

/* verification/tb_ip_rx.sv */
// testbench top for the IPv4 receiver, builds frames, drives the DUT and reports the result
`timescale 1ns/1ps

module tb_ip_rx;

    logic                  clk;
    logic                  rst;
    ip_rx_pkg::axis_beat_t in_beat;
    logic                  in_valid;
    logic                  in_ready;
    ip_rx_pkg::ip_hdr_t    hdr;
    logic                  hdr_valid;
    logic                  hdr_ready;
    ip_rx_pkg::axis_beat_t out_beat;
    logic                  out_valid;
    logic                  out_ready;
    logic                  error_invalid_header;
    logic                  error_invalid_checksum;

    logic [15:0] lfsr_state;
    logic [7:0]  frame[$];
    logic        random_mode;
    logic        timed_out;
    int          frame_count;
    int          frames_before;
    int          test_count;
    int          max_wait;

    ip_rx_top ip_rx_top_i (
        .clk                   (clk),
        .rst                   (rst),
        .in_beat               (in_beat),
        .in_valid              (in_valid),
        .in_ready              (in_ready),
        .hdr                   (hdr),
        .hdr_valid             (hdr_valid),
        .hdr_ready             (hdr_ready),
        .out_beat              (out_beat),
        .out_valid             (out_valid),
        .out_ready             (out_ready),
        .error_invalid_header  (error_invalid_header),
        .error_invalid_checksum(error_invalid_checksum)
    );

    ip_rx_checker ip_rx_checker_i (
        .clk                   (clk),
        .rst                   (rst),
        .hdr                   (hdr),
        .hdr_valid             (hdr_valid),
        .hdr_ready             (hdr_ready),
        .out_beat              (out_beat),
        .out_valid             (out_valid),
        .out_ready             (out_ready),
        .error_invalid_header  (error_invalid_header),
        .error_invalid_checksum(error_invalid_checksum)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci LFSR, taps 16 14 13 11, one step per bit taken
    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[14:0], fb};
        end
        return r;
    endfunction

    // one falling edge, readies change here only
    task automatic next_cycle();
        @(negedge clk);
        if (random_mode) begin
            hdr_ready = (random_bits(1) != 16'd0);
            out_ready = (random_bits(2) != 16'd0);
        end else begin
            hdr_ready = 1'b1;
            out_ready = 1'b1;
        end
    endtask

    task automatic build_frame(input int total_length, input int pad, input int flip_bit,
                               input logic [7:0] first_byte);
        logic [31:0] sum;
        logic [15:0] checksum;
        frame.delete();
        frame.push_back(first_byte);
        frame.push_back(8'(random_bits(8)));
        frame.push_back(total_length[15:8]);
        frame.push_back(total_length[7:0]);
        // identification, flags, offset, ttl, protocol
        repeat (6) frame.push_back(8'(random_bits(8)));
        frame.push_back(8'd0);
        frame.push_back(8'd0);
        repeat (8 + total_length - 20 + pad) frame.push_back(8'(random_bits(8)));
        sum = '0;
        for (int i = 0; i < 20; i += 2) begin
            sum = sum + 32'({frame[i], frame[i + 1]});
        end
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        checksum = ~sum[15:0];
        frame[10] = checksum[15:8];
        frame[11] = checksum[7:0];
        if (flip_bit >= 0) begin
            frame[flip_bit / 8] = frame[flip_bit / 8] ^ 8'(1 << (flip_bit % 8));
        end
    endtask

    task automatic send_beat(input ip_rx_pkg::axis_beat_t beat);
        int waited;
        waited = 0;
        if (timed_out) begin
            return;
        end
        in_beat = beat;
        in_valid = 1'b1;
        // in_ready is registered, so its level here holds through the next rising edge
        while (!in_ready && waited < max_wait) begin
            next_cycle();
            waited++;
        end
        if (!in_ready) begin
            timed_out = 1'b1;
            in_valid = 1'b0;
            $display("timeout: the DUT did not accept an input beat");
            return;
        end
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic send_frame(input int total_length, input int pad, input int flip_bit,
                              input logic [7:0] first_byte);
        ip_rx_pkg::axis_beat_t beat;
        int n;
        build_frame(total_length, pad, flip_bit, first_byte);
        ip_rx_checker_i.expect_frame(frame);
        frame_count++;
        for (int base = 0; base < frame.size(); base += 8) begin
            beat = '0;
            n = frame.size() - base;
            if (n > 8) begin
                n = 8;
            end
            for (int i = 0; i < n; i++) begin
                beat.data[i*8 +: 8] = frame[base + i];
                beat.keep[i] = 1'b1;
            end
            beat.last = (base + 8 >= frame.size());
            while (random_mode && random_bits(2) == 16'd0) begin
                in_valid = 1'b0;
                next_cycle();
            end
            send_beat(beat);
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while (!timed_out && !ip_rx_checker_i.drained() && waited < max_wait) begin
            next_cycle();
            waited++;
        end
        if (!timed_out && !ip_rx_checker_i.drained()) begin
            timed_out = 1'b1;
            $display("timeout: headers, payload or error pulses still outstanding");
        end
        ip_rx_checker_i.check_pulse_counts();
        test_count++;
        $display("test %s done, %0d frames, %0d errors so far", name,
                 frame_count - frames_before, ip_rx_checker_i.errors);
        frames_before = frame_count;
    endtask

    initial begin
        int tl;
        int pad;
        rst = 1'b1;
        in_beat = '0;
        in_valid = 1'b0;
        hdr_ready = 1'b1;
        out_ready = 1'b1;
        random_mode = 1'b0;
        timed_out = 1'b0;
        frame_count = 0;
        frames_before = 0;
        test_count = 0;
        max_wait = 5000;
        // seed reduced to the 16-bit register
        lfsr_state = 16'(85873);
        repeat (8) next_cycle();
        rst = 1'b0;

        for (int t = 20; t <= 120; t += 10) begin
            send_frame(t, 0, -1, 8'h45);
        end
        finish_test("good_frames");

        // every payload remainder, short ones need the closing beat
        for (int t = 21; t <= 28; t++) begin
            send_frame(t, 0, -1, 8'h45);
        end
        for (int t = 52; t < 68; t++) begin
            send_frame(t, 0, -1, 8'h45);
        end
        finish_test("byte_alignment");

        send_frame(30, 16, -1, 8'h45);
        send_frame(20, 26, -1, 8'h45);
        for (int k = 0; k < 8; k++) begin
            tl = 20 + int'(random_bits(6));
            pad = 1 + int'(random_bits(4));
            send_frame(tl, pad, -1, 8'h45);
        end
        finish_test("trimming");

        for (int k = 0; k < 4; k++) begin
            send_frame(28 + 9 * k, 0, 8 + int'(random_bits(7)), 8'h45);
            send_frame(40, 0, -1, 8'h45);
        end
        finish_test("bad_checksum");

        send_frame(48, 0, -1, 8'h65);
        send_frame(48, 0, -1, 8'h45);
        send_frame(60, 0, -1, 8'h46);
        send_frame(33, 0, -1, 8'h45);
        send_frame(20, 0, -1, 8'h35);
        send_frame(52, 0, -1, 8'h44);
        send_frame(44, 0, -1, 8'h45);
        finish_test("bad_version_ihl");

        random_mode = 1'b1;
        for (int k = 0; k < 24; k++) begin
            tl = 20 + int'(random_bits(7));
            pad = int'(random_bits(3));
            send_frame(tl, pad, -1, 8'h45);
        end
        finish_test("back_pressure");
        random_mode = 1'b0;

        $display("%0d tests, %0d frames, %0d checks, %0d errors", test_count, frame_count,
                 ip_rx_checker_i.checks, ip_rx_checker_i.errors);
        if (timed_out || ip_rx_checker_i.errors != 0) begin
            $display("ERRORS FOUND");
        end else begin
            $display("NO ERRORS");
        end
        $finish;
    end

endmodule

/* files.f */
source/ip_rx_pkg.sv
source/ip_hdr_capture.sv
source/ip_hdr_checksum.sv
source/payload_realign.sv
source/payload_skid_buffer.sv
source/ip_rx_ctrl.sv
source/ip_rx_top.sv
verification/ip_rx_checker.sv
verification/tb_ip_rx.sv

/* Makefile */
SOURCES := $(wildcard source/*.sv verification/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_ip_rx
	./obj_dir/Vtb_ip_rx | tee run.log
	grep -qx "NO ERRORS" run.log

obj_dir/Vtb_ip_rx: $(SOURCES) files.f
	verilator --binary --top-module tb_ip_rx -f files.f

clean:
	rm -rf obj_dir run.log
